/* include/execUnit_config.svh */
`ifndef EXEC_UNIT_CONFIG_SVH
`define EXEC_UNIT_CONFIG_SVH

// Memory address and data word widths
`define EXEC_ADDR_WIDTH 12
`define EXEC_DATA_WIDTH 12

// PC value after reset, octal 200
`define EXEC_START_ADDR 'o200

// Stall length in cycles after the acceptance edge
// NOP, CLA_CLL, DCA, JMS and JMP
`define EXEC_LAT_SHORT 3

// AND and TAD need a read and a capture first
`define EXEC_LAT_READ 4

// ISZ reads, increments and writes back
`define EXEC_LAT_ISZ 5

`endif

/* hw/execPkg.sv */
`default_nettype none

`include "execUnit_config.svh"

package execPkg;

    // Memory address
    typedef logic [`EXEC_ADDR_WIDTH-1:0] addr_t;

    // Memory word, also the accumulator
    typedef logic [`EXEC_DATA_WIDTH-1:0] data_t;

    // Cycles since acceptance, zero when idle
    typedef logic [2:0] phase_t;

    // Instructions the unit executes
    typedef enum logic [3:0] {
        OpAnd,
        OpTad,
        OpIsz,
        OpDca,
        OpJms,
        OpJmp,
        OpNop,
        OpClaCll
    } opcode_t;

    // Sequencer states
    typedef enum logic {
        Idle,
        Busy
    } seqState_t;

endpackage

`default_nettype wire

/* hw/execCtrlIf.sv */
`default_nettype none

interface execCtrlIf import execPkg::*; ();

    // Instruction held for the whole execution
    opcode_t curOp;
    addr_t   operandAddr;

    // One-cycle strobes
    logic issueRead;
    logic issueWrite;
    logic captureRead;
    logic finish;

    modport seq (
        output curOp,
        output operandAddr,
        output issueRead,
        output issueWrite,
        output captureRead,
        output finish
    );

    modport dp (
        input curOp,
        input operandAddr,
        input issueRead,
        input issueWrite,
        input captureRead,
        input finish
    );

endinterface

`default_nettype wire

/* hw/execSequencer.sv */
`default_nettype none

`include "execUnit_config.svh"

module execSequencer import execPkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    instrValid,
    input  opcode_t instrOp,
    input  addr_t   instrAddr,
    input  logic    lastCycle,
    input  phase_t  phase,
    output logic    stall,
    output logic    load,
    output phase_t  latency,
    execCtrlIf.seq  ctrl
);

    seqState_t state;
    logic      busy;
    logic      readOp;
    logic      earlyWriteOp;

    assign busy  = (state == Busy);
    assign stall = busy;

    // instrValid is ignored while busy
    assign load = !busy && instrValid;

    // Latency of the incoming opcode, loaded into the timer on acceptance
    always_comb begin
        case (instrOp)
            OpAnd, OpTad: latency = phase_t'(`EXEC_LAT_READ);
            OpIsz:        latency = phase_t'(`EXEC_LAT_ISZ);
            default:      latency = phase_t'(`EXEC_LAT_SHORT);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: if (load) state <= Busy;
                Busy: if (lastCycle) state <= Idle;
                default: state <= Idle;
            endcase
        end
    end

    // Hold the instruction until the next acceptance
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ctrl.curOp <= OpNop;
        end else if (load) begin
            ctrl.curOp <= instrOp;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ctrl.operandAddr <= instrAddr;
        end
    end

    assign readOp       = (ctrl.curOp == OpAnd) || (ctrl.curOp == OpTad) ||
                          (ctrl.curOp == OpIsz);
    assign earlyWriteOp = (ctrl.curOp == OpDca) || (ctrl.curOp == OpJms);

    // Read in cycle 1, capture in cycle 2
    assign ctrl.issueRead   = busy && readOp && (phase == 3'd1);
    assign ctrl.captureRead = busy && readOp && (phase == 3'd2);

    // DCA and JMS write in cycle 1, ISZ writes back in cycle 3
    assign ctrl.issueWrite = busy && ((earlyWriteOp && (phase == 3'd1)) ||
                                      ((ctrl.curOp == OpIsz) && (phase == 3'd3)));

    assign ctrl.finish = busy && lastCycle;

endmodule

`default_nettype wire

/* hw/phaseTimer.sv */
`default_nettype none

module phaseTimer import execPkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   load,
    input  phase_t latency,
    output phase_t phase,
    output logic   lastCycle
);

    phase_t loadedLatency;

    // Phase is 1 in the cycle after load and returns to zero after the last cycle
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase <= '0;
        end else if (load) begin
            phase <= phase_t'(1);
        end else if (lastCycle) begin
            phase <= '0;
        end else if (phase != '0) begin
            phase <= phase + phase_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            loadedLatency <= latency;
        end
    end

    // Never asserted while idle
    assign lastCycle = (phase != '0) && (phase == loadedLatency);

endmodule

`default_nettype wire

/* hw/memoryPort.sv */
`default_nettype none

module memoryPort import execPkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  data_t  rdData,
    input  data_t  acc,
    input  addr_t  pcNext,
    output logic   rdReq,
    output addr_t  rdAddr,
    output logic   wrReq,
    output addr_t  wrAddr,
    output data_t  wrData,
    output data_t  memWord,
    output logic   incZero,
    execCtrlIf.dp  ctrl
);

    data_t incWord;

    // Requests follow the strobes in the same cycle
    assign rdReq  = ctrl.issueRead;
    assign wrReq  = ctrl.issueWrite;

    // Reads and writes always target the operand address
    assign rdAddr = ctrl.operandAddr;
    assign wrAddr = ctrl.operandAddr;

    // Memory answers one cycle after the request
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            memWord <= '0;
        end else if (ctrl.captureRead) begin
            memWord <= rdData;
        end
    end

    assign incWord = memWord + data_t'(1);

    // Skip condition for ISZ
    assign incZero = (incWord == '0);

    always_comb begin
        case (ctrl.curOp)
            OpIsz:   wrData = incWord;
            // Return address of the subroutine call
            OpJms:   wrData = data_t'(pcNext);
            default: wrData = acc;
        endcase
    end

endmodule

`default_nettype wire

/* hw/accumulatorUnit.sv */
`default_nettype none

module accumulatorUnit import execPkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  data_t memWord,
    output data_t acc,
    output logic  link,
    execCtrlIf.dp ctrl
);

    data_t sum;
    logic  carry;

    // Twelve-bit add with carry out for TAD
    assign {carry, sum} = {1'b0, acc} + {1'b0, memWord};

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            acc  <= '0;
            link <= 1'b0;
        end else if (ctrl.finish) begin
            case (ctrl.curOp)
                OpAnd: begin
                    acc <= acc & memWord;
                end
                OpTad: begin
                    acc  <= sum;
                    // Carry complements the link
                    link <= link ^ carry;
                end
                OpDca: begin
                    acc <= '0;
                end
                OpClaCll: begin
                    acc  <= '0;
                    link <= 1'b0;
                end
                default: begin
                    acc <= acc;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/programCounter.sv */
`default_nettype none

`include "execUnit_config.svh"

module programCounter import execPkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  incZero,
    output addr_t pcValue,
    output addr_t pcNext,
    execCtrlIf.dp ctrl
);

    // Also the JMS return address
    assign pcNext = pcValue + addr_t'(1);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pcValue <= addr_t'(`EXEC_START_ADDR);
        end else if (ctrl.finish) begin
            case (ctrl.curOp)
                OpJmp: begin
                    pcValue <= ctrl.operandAddr;
                end
                OpJms: begin
                    // Return address sits at operandAddr, body starts after it
                    pcValue <= ctrl.operandAddr + addr_t'(1);
                end
                OpIsz: begin
                    // Skip the next instruction when the word wrapped to zero
                    pcValue <= incZero ? pcValue + addr_t'(2) : pcNext;
                end
                default: begin
                    pcValue <= pcNext;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/execUnit.sv */
`default_nettype none

module execUnit import execPkg::*; (
    input  logic    clk,
    input  logic    reset_n,

    // Decoder side
    input  logic    instrValid,
    input  opcode_t instrOp,
    input  addr_t   instrAddr,
    output logic    stall,
    output addr_t   pcValue,

    // Memory read port
    output logic    rdReq,
    output addr_t   rdAddr,
    input  data_t   rdData,

    // Memory write port
    output logic    wrReq,
    output addr_t   wrAddr,
    output data_t   wrData,

    // Front panel
    output data_t   acc,
    output logic    link
);

    logic   load;
    logic   lastCycle;
    phase_t latency;
    phase_t phase;
    data_t  memWord;
    logic   incZero;
    addr_t  pcNext;

    execCtrlIf ctrlBus ();

    execSequencer sequencer (
        .clk        (clk),
        .reset_n    (reset_n),
        .instrValid (instrValid),
        .instrOp    (instrOp),
        .instrAddr  (instrAddr),
        .lastCycle  (lastCycle),
        .phase      (phase),
        .stall      (stall),
        .load       (load),
        .latency    (latency),
        .ctrl       (ctrlBus.seq)
    );

    phaseTimer timer (
        .clk       (clk),
        .reset_n   (reset_n),
        .load      (load),
        .latency   (latency),
        .phase     (phase),
        .lastCycle (lastCycle)
    );

    memoryPort memPort (
        .clk     (clk),
        .reset_n (reset_n),
        .rdData  (rdData),
        .acc     (acc),
        .pcNext  (pcNext),
        .rdReq   (rdReq),
        .rdAddr  (rdAddr),
        .wrReq   (wrReq),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .memWord (memWord),
        .incZero (incZero),
        .ctrl    (ctrlBus.dp)
    );

    accumulatorUnit accUnit (
        .clk     (clk),
        .reset_n (reset_n),
        .memWord (memWord),
        .acc     (acc),
        .link    (link),
        .ctrl    (ctrlBus.dp)
    );

    programCounter pc (
        .clk     (clk),
        .reset_n (reset_n),
        .incZero (incZero),
        .pcValue (pcValue),
        .pcNext  (pcNext),
        .ctrl    (ctrlBus.dp)
    );

endmodule

`default_nettype wire

/* verif/execUnitTb.sv */
`default_nettype none

`include "execUnit_config.svh"

module execUnitTb import execPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TimeoutCycles = 20;

    logic    clk;
    logic    reset_n;
    logic    instrValid;
    opcode_t instrOp;
    addr_t   instrAddr;
    logic    stall;
    addr_t   pcValue;
    logic    rdReq;
    addr_t   rdAddr;
    data_t   rdData;
    logic    wrReq;
    addr_t   wrAddr;
    data_t   wrData;
    data_t   acc;
    logic    link;

    // DUT memory and the reference copy
    data_t mem [0:4095];
    data_t refMem [0:4095];
    data_t refAcc;
    logic  refLink;
    addr_t refPc;
    int    errors;
    int    tests;
    bit    hung;

    execUnit DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Read data one cycle after the request, writes land on the edge
    always @(posedge clk) begin
        if (rdReq) rdData <= mem[rdAddr];
        if (wrReq) mem[wrAddr] <= wrData;
    end

    task automatic reportMismatch(input string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    task automatic endTest(input string name);
        tests++;
        $display("Test %s finished, %0d errors so far", name, errors);
    endtask

    // Single-cycle request pulses, and no requests while idle
    assert property (@(posedge clk) disable iff (!reset_n) rdReq |=> !rdReq)
        else reportMismatch("rdReq longer than one cycle");
    assert property (@(posedge clk) disable iff (!reset_n) wrReq |=> !wrReq)
        else reportMismatch("wrReq longer than one cycle");
    assert property (@(posedge clk) disable iff (!reset_n) !stall |-> !rdReq && !wrReq)
        else reportMismatch("memory request while idle");

    task automatic setWord(input addr_t a, input data_t v);
        mem[a] <= v;
        refMem[a] = v;
    endtask

    function automatic int expLatency(input opcode_t op);
        case (op)
            OpAnd, OpTad: return `EXEC_LAT_READ;
            OpIsz:        return `EXEC_LAT_ISZ;
            default:      return `EXEC_LAT_SHORT;
        endcase
    endfunction

    task automatic runInstr(input opcode_t op, input addr_t addr, input bit noise);
        data_t expAcc;
        logic  expLink;
        addr_t expPc;
        data_t expWr;
        data_t word;
        logic [`EXEC_DATA_WIDTH:0] s;
        int    wrCyc;
        int    cyc;
        bit    isRead;
        if (hung) return;
        word = refMem[addr];
        expAcc = refAcc;
        expLink = refLink;
        expPc = refPc + addr_t'(1);
        expWr = '0;
        wrCyc = 0;
        isRead = (op == OpAnd) || (op == OpTad) || (op == OpIsz);
        case (op)
            OpAnd: expAcc = refAcc & word;
            OpTad: begin
                s = {1'b0, refAcc} + {1'b0, word};
                expAcc = s[`EXEC_DATA_WIDTH-1:0];
                expLink = refLink ^ s[`EXEC_DATA_WIDTH];
            end
            OpIsz: begin
                expWr = word + data_t'(1);
                wrCyc = 3;
                if (expWr == '0) expPc = refPc + addr_t'(2);
            end
            OpDca: begin
                expWr = refAcc;
                wrCyc = 1;
                expAcc = '0;
            end
            OpJms: begin
                expWr = data_t'(refPc + addr_t'(1));
                wrCyc = 1;
                expPc = addr + addr_t'(1);
            end
            OpJmp: expPc = addr;
            OpClaCll: begin
                expAcc = '0;
                expLink = 1'b0;
            end
            default: ;
        endcase
        @(posedge clk);
        instrValid <= 1'b1;
        instrOp <= op;
        instrAddr <= addr;
        @(posedge clk);
        instrValid <= 1'b0;
        cyc = 0;
        @(negedge clk);
        while (stall && cyc <= TimeoutCycles) begin
            cyc++;
            assert (rdReq == (isRead && cyc == 1)) else reportMismatch("rdReq in wrong cycle");
            if (rdReq) assert (rdAddr == addr) else reportMismatch("wrong rdAddr");
            assert (wrReq == (wrCyc != 0 && cyc == wrCyc))
                else reportMismatch("wrReq in wrong cycle");
            if (wrReq) assert (wrAddr == addr && wrData == expWr)
                else reportMismatch($sformatf("write %o to %o, expected %o", wrData, wrAddr, expWr));
            // A request during stall must be ignored
            if (noise && cyc <= 2) begin
                @(posedge clk);
                instrValid <= (cyc == 1);
                instrOp <= OpJmp;
                instrAddr <= ~addr;
            end
            @(negedge clk);
        end
        if (cyc > TimeoutCycles) begin
            hung = 1'b1;
            $display("Stall did not fall within %0d cycles at time %0t", TimeoutCycles, $time);
        end else begin
            assert (cyc == expLatency(op))
                else reportMismatch($sformatf("%s stall %0d cycles", op.name(), cyc));
            assert (acc == expAcc) else reportMismatch($sformatf("acc %o expected %o", acc, expAcc));
            assert (link == expLink) else reportMismatch("wrong link");
            assert (pcValue == expPc)
                else reportMismatch($sformatf("PC %o expected %o", pcValue, expPc));
        end
        refAcc = expAcc;
        refLink = expLink;
        refPc = expPc;
        if (wrCyc != 0) refMem[addr] = expWr;
    endtask

    initial begin
        void'($urandom(55631));
        errors = 0;
        tests = 0;
        hung = 1'b0;
        reset_n = 1'b0;
        instrValid = 1'b0;
        instrOp = OpNop;
        instrAddr = '0;
        rdData = '0;
        // Fill depends on every address bit
        for (int i = 0; i < 4096; i++) begin
            setWord(addr_t'(i), data_t'(i * 'o41) ^ data_t'(i >> 5));
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (!stall && !rdReq && !wrReq) else reportMismatch("control active in reset");
        assert (pcValue == addr_t'(`EXEC_START_ADDR)) else reportMismatch("PC not at start");
        assert (acc == '0 && !link) else reportMismatch("acc or link not clear");
        @(posedge clk);
        reset_n <= 1'b1;
        refAcc = '0;
        refLink = 1'b0;
        refPc = addr_t'(`EXEC_START_ADDR);
        endTest("reset");

        for (int i = 0; i < 8; i++) runInstr(opcode_t'(i), addr_t'('o300 + i), 1'b1);
        endTest("latency");

        @(negedge clk);
        setWord('o400, 'o7070);
        setWord('o401, 'o7777);
        setWord('o402, 'o0033);
        runInstr(OpClaCll, '0, 1'b0);
        runInstr(OpTad, 'o401, 1'b0);
        runInstr(OpTad, 'o402, 1'b0);
        runInstr(OpAnd, 'o400, 1'b0);
        endTest("and_tad");

        runInstr(OpDca, 'o410, 1'b0);
        runInstr(OpTad, 'o400, 1'b0);
        runInstr(OpClaCll, '0, 1'b0);
        @(negedge clk);
        assert (mem['o410] == refMem['o410]) else reportMismatch("DCA word not in memory");
        endTest("dca_cla");

        @(negedge clk);
        setWord('o420, 'o7777);
        runInstr(OpIsz, 'o420, 1'b0);
        runInstr(OpIsz, 'o420, 1'b0);
        endTest("isz");

        runInstr(OpJmp, 'o1000, 1'b0);
        runInstr(OpJms, 'o2000, 1'b0);
        endTest("jmp_jms");

        for (int n = 0; n < 200; n++) begin
            addr_t a;
            a = addr_t'($urandom);
            @(negedge clk);
            if ($urandom_range(0, 1) == 1) setWord(a, data_t'($urandom));
            runInstr(opcode_t'($urandom_range(0, 7)), a, 1'b0);
        end
        endTest("random");

        $display("Tests %0d, errors %0d", tests, errors);
        if (errors == 0 && !hung) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* execUnit.f */
+incdir+include
hw/execPkg.sv
hw/execCtrlIf.sv
hw/execSequencer.sv
hw/phaseTimer.sv
hw/memoryPort.sv
hw/accumulatorUnit.sv
hw/programCounter.sv
hw/execUnit.sv
verif/execUnitTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = execUnitTb
FILELIST = execUnit.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '>>> PASS'

clean:
	rm -rf $(OBJDIR)
